// File: mem_cfg_pkg.sv
package mem_cfg_pkg;

    // ------------------------------
    // Walker address and data widths
    // ------------------------------
    localparam int ADDR_W     = 40;  // Walker physical address
    localparam int WORD_W     = 64;  // One doubleword
    localparam int BE_W       = WORD_W / 8;

    // ------------------------------
    // Request line geometry
    // ------------------------------
    localparam int REQ_WORDS  = 2;   // Words per requester line
    localparam int LANE_W     = 1;   // Lane select bits
    localparam int OFFSET_LSB = 3;   // Doubleword offset inside the line

    // Line store, direct indexed
    localparam int ROW_W      = 6;
    localparam int ROWS       = 64;
    localparam int ROW_LSB    = OFFSET_LSB + LANE_W;  // Row field sits above the lane

    // ------------------------------
    // Line types
    // ------------------------------

    // Word w of the line holds address offset w*8
    typedef logic [REQ_WORDS-1:0][WORD_W-1:0] line_t;

    // One byte enable group per word
    typedef logic [REQ_WORDS-1:0][BE_W-1:0] be_line_t;

endpackage

// File: ptw_mem_pkg.sv
package ptw_mem_pkg;

    // ------------------------------
    // Walker commands and operations
    // ------------------------------

    // Codes as issued by the walker
    typedef enum logic [4:0] {
        CMD_LOAD   = 5'b00000,
        CMD_AMO_OR = 5'b01010  // Sets A/D bits in a PTE
    } ptw_cmd_e;

    // What the line store actually does
    typedef enum logic {
        OP_LOAD,
        OP_AMO_OR
    } mem_op_e;

    // ------------------------------
    // Request and pipeline structs
    // ------------------------------
    typedef struct packed {
        logic [mem_cfg_pkg::ADDR_W-1:0] addr;
        ptw_cmd_e                       cmd;
        logic [mem_cfg_pkg::WORD_W-1:0] data;
    } ptw_req_t;

    typedef struct packed {
        mem_op_e                        op;
        logic [mem_cfg_pkg::ROW_W-1:0]  row;
        logic [mem_cfg_pkg::LANE_W-1:0] lane;
        mem_cfg_pkg::line_t             wdata;  // Data only in the selected lane
        mem_cfg_pkg::be_line_t          be;
    } dec_req_t;

    typedef struct packed {
        mem_cfg_pkg::line_t             rdata;  // Line before the update
        logic [mem_cfg_pkg::LANE_W-1:0] lane;
    } exe_line_t;

    // Addressed doubleword of a read line
    function automatic logic [mem_cfg_pkg::WORD_W-1:0] select_word(input exe_line_t line);
        return line.rdata[line.lane];
    endfunction

endpackage

// File: ptw_req_decode.sv
module ptw_req_decode (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  req_valid_i,
    input  ptw_mem_pkg::ptw_req_t req_i,
    input  logic                  store_ready_i,
    output logic                  dec_valid_o,
    output ptw_mem_pkg::dec_req_t dec_req_o
);

    import mem_cfg_pkg::*;
    import ptw_mem_pkg::*;

    logic     accept;
    dec_req_t dec_d;
    dec_req_t dec_q;
    logic     dec_valid_q;

    assign accept = req_valid_i & store_ready_i;

    // ------------------------------
    // Command decode and lane placement
    // ------------------------------
    always_comb begin
        // Anything but the AMO-OR code is a plain load
        dec_d.op   = (req_i.cmd == CMD_AMO_OR) ? OP_AMO_OR : OP_LOAD;
        dec_d.row  = req_i.addr[ROW_LSB +: ROW_W];
        dec_d.lane = req_i.addr[OFFSET_LSB +: LANE_W];

        for (int w = 0; w < REQ_WORDS; w++) begin
            if (dec_d.lane == LANE_W'(w)) begin
                dec_d.wdata[w] = req_i.data;
                dec_d.be[w]    = (dec_d.op == OP_AMO_OR) ? '1 : '0;  // Loads write nothing
            end else begin
                dec_d.wdata[w] = '0;
                dec_d.be[w]    = '0;
            end
        end
    end

    // ------------------------------
    // Stage register
    // ------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            dec_valid_q <= 1'b0;
        end else begin
            dec_valid_q <= accept;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            dec_q <= dec_d;
        end
    end

    assign dec_valid_o = dec_valid_q;
    assign dec_req_o   = dec_q;

endmodule

// File: line_store_execute.sv
module line_store_execute (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   dec_valid_i,
    input  ptw_mem_pkg::dec_req_t  dec_req_i,
    output logic                   store_ready_o,
    output logic                   line_valid_o,
    output ptw_mem_pkg::exe_line_t line_o
);

    import mem_cfg_pkg::*;
    import ptw_mem_pkg::*;

    line_t            mem [ROWS];
    line_t            old_line;
    line_t            merged_line;
    logic             do_write;

    logic [ROW_W-1:0] clr_row_q;
    logic             clearing_q;

    exe_line_t        line_q;
    logic             line_valid_q;

    // ------------------------------
    // Post-reset clear
    // ------------------------------

    // One row per cycle, ready stays low until the last row is done
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            clr_row_q  <= '0;
            clearing_q <= 1'b1;
        end else if (clearing_q) begin
            clr_row_q <= clr_row_q + 1'b1;
            if (clr_row_q == ROW_W'(ROWS - 1)) begin
                clearing_q <= 1'b0;
            end
        end
    end

    assign store_ready_o = ~clearing_q;

    // ------------------------------
    // Read-modify-write
    // ------------------------------
    assign old_line = mem[dec_req_i.row];

    // AMO-OR merge, byte by byte under the enables
    always_comb begin
        for (int w = 0; w < REQ_WORDS; w++) begin
            for (int b = 0; b < BE_W; b++) begin
                if (dec_req_i.be[w][b]) begin
                    merged_line[w][b*8 +: 8] = old_line[w][b*8 +: 8] |
                                               dec_req_i.wdata[w][b*8 +: 8];
                end else begin
                    merged_line[w][b*8 +: 8] = old_line[w][b*8 +: 8];
                end
            end
        end
    end

    assign do_write = dec_valid_i & (dec_req_i.op == OP_AMO_OR);  // Loads leave the row alone

    always_ff @(posedge clk_i) begin
        if (clearing_q) begin
            mem[clr_row_q] <= '0;
        end else if (do_write) begin
            mem[dec_req_i.row] <= merged_line;  // Lands before the next read
        end
    end

    // ------------------------------
    // Read line register
    // ------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            line_valid_q <= 1'b0;
        end else begin
            line_valid_q <= dec_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (dec_valid_i) begin
            line_q.rdata <= old_line;  // Old value, also for the AMO
            line_q.lane  <= dec_req_i.lane;
        end
    end

    assign line_valid_o = line_valid_q;
    assign line_o       = line_q;

endmodule

// File: word_result.sv
module word_result (
    input  logic                             clk_i,
    input  logic                             rst_n_i,
    input  logic                             line_valid_i,
    input  ptw_mem_pkg::exe_line_t           line_i,
    output logic                             rsp_valid_o,
    output logic [mem_cfg_pkg::WORD_W-1:0]   rsp_data_o
);

    import mem_cfg_pkg::*;
    import ptw_mem_pkg::*;

    logic              rsp_valid_q;
    logic [WORD_W-1:0] rsp_data_q;

    // ------------------------------
    // Response register
    // ------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rsp_valid_q <= 1'b0;
        end else begin
            rsp_valid_q <= line_valid_i;  // Single cycle pulse, no back-pressure
        end
    end

    // Lane picks the doubleword, as the decode placed it
    always_ff @(posedge clk_i) begin
        if (line_valid_i) begin
            rsp_data_q <= select_word(line_i);
        end
    end

    assign rsp_valid_o = rsp_valid_q;
    assign rsp_data_o  = rsp_data_q;

endmodule

// File: ptw_dmem_bridge.sv
module ptw_dmem_bridge (
    input  logic                           clk_i,
    input  logic                           rst_n_i,

    // Walker request, valid/ready
    input  logic                           req_valid_i,
    input  ptw_mem_pkg::ptw_req_t          req_i,
    output logic                           req_ready_o,

    // Response, in order, no ready
    output logic                           rsp_valid_o,
    output logic [mem_cfg_pkg::WORD_W-1:0] rsp_data_o
);

    import mem_cfg_pkg::*;
    import ptw_mem_pkg::*;

    logic      store_ready;
    logic      dec_valid;
    dec_req_t  dec_req;
    logic      line_valid;
    exe_line_t line;

    assign req_ready_o = store_ready;  // Low only during the clear

    // ------------------------------
    // Decode stage
    // ------------------------------
    ptw_req_decode i_ptw_req_decode (
        .clk_i         ( clk_i       ),
        .rst_n_i       ( rst_n_i     ),
        .req_valid_i   ( req_valid_i ),
        .req_i         ( req_i       ),
        .store_ready_i ( store_ready ),
        .dec_valid_o   ( dec_valid   ),
        .dec_req_o     ( dec_req     )
    );

    // ------------------------------
    // Line store
    // ------------------------------
    line_store_execute i_line_store_execute (
        .clk_i         ( clk_i       ),
        .rst_n_i       ( rst_n_i     ),
        .dec_valid_i   ( dec_valid   ),
        .dec_req_i     ( dec_req     ),
        .store_ready_o ( store_ready ),
        .line_valid_o  ( line_valid  ),
        .line_o        ( line        )
    );

    // ------------------------------
    // Word select and response
    // ------------------------------
    word_result i_word_result (
        .clk_i        ( clk_i       ),
        .rst_n_i      ( rst_n_i     ),
        .line_valid_i ( line_valid  ),
        .line_i       ( line        ),
        .rsp_valid_o  ( rsp_valid_o ),
        .rsp_data_o   ( rsp_data_o  )
    );

endmodule

// File: tb_ptw_dmem_bridge.sv
module tb_ptw_dmem_bridge;

    import mem_cfg_pkg::*;
    import ptw_mem_pkg::*;

    localparam int CLK_PERIOD = 20;
    localparam int RST_CYCLES = 5;
    localparam logic [31:0] SEED = 32'h39bdb4fd;

    // Requests per test
    localparam int N_T1  = 4;
    localparam int N_T2  = 8;    // Two passes over both lanes
    localparam int N_T3  = 8;
    localparam int N_T4  = 16;   // Odd command plus load, eight times
    localparam int N_T5  = 200;
    localparam int N_REQ = N_T1 + N_T2 + N_T3 + N_T4 + N_T5;

    localparam int MARGIN        = 200;
    localparam int WATCHDOG_TIME = (N_REQ * 4 + ROWS + RST_CYCLES + MARGIN) * CLK_PERIOD;

    logic              clk_i;
    logic              rst_n_i;
    logic              req_valid_i;
    ptw_req_t          req_i;
    logic              req_ready_o;
    logic              rsp_valid_o;
    logic [WORD_W-1:0] rsp_data_o;

    logic [WORD_W-1:0] model [ROWS][REQ_WORDS];  // Expected store contents
    logic [WORD_W-1:0] exp_q [$];
    time               acc_q [$];                // Acceptance times, same order
    logic [ADDR_W-1:0] amo_addr [REQ_WORDS];
    logic [31:0]       rng_state;
    logic              ready_seen;
    int                pass_cnt;
    int                err_cnt;

    ptw_dmem_bridge i_ptw_dmem_bridge (
        .clk_i       ( clk_i       ),
        .rst_n_i     ( rst_n_i     ),
        .req_valid_i ( req_valid_i ),
        .req_i       ( req_i       ),
        .req_ready_o ( req_ready_o ),
        .rsp_valid_o ( rsp_valid_o ),
        .rsp_data_o  ( rsp_data_o  )
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // ------------------------------
    // Helpers and reference model
    // ------------------------------
    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic logic [ADDR_W-1:0] rand_addr();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = next_rand();
        lo = next_rand();
        return {hi[7:0], lo};
    endfunction

    // Row in address bits 9:4, lane in bit 3, higher bits ignored
    function automatic logic [WORD_W-1:0] ref_access(input logic [ADDR_W-1:0] addr,
                                                     input logic [4:0]        cmd,
                                                     input logic [WORD_W-1:0] data);
        logic [5:0]        row;
        logic              lane;
        logic [WORD_W-1:0] old;
        row  = addr[9:4];
        lane = addr[3];
        old  = model[row][lane];
        if (cmd == 5'b01010) begin
            model[row][lane] = old | data;  // Atomic OR
        end
        return old;
    endfunction

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("Error: time %0t, %s mismatch, got %h, expected %h",
                     $time, what, got, exp);
            err_cnt++;
        end else begin
            pass_cnt++;
        end
    endtask

    task automatic send(input logic [ADDR_W-1:0] addr, input logic [4:0] cmd,
                        input logic [WORD_W-1:0] data);
        ptw_req_t r;
        r.addr = addr;
        r.cmd  = ptw_cmd_e'(cmd);
        r.data = data;
        req_valid_i <= 1'b1;
        req_i       <= r;
        @(posedge clk_i);
        while (!req_ready_o) begin
            @(posedge clk_i);
        end
        exp_q.push_back(ref_access(addr, cmd, data));
        acc_q.push_back($time);
    endtask

    task automatic drain();
        req_valid_i <= 1'b0;
        @(posedge clk_i);
        while (exp_q.size() != 0) begin
            @(posedge clk_i);
        end
        repeat (2) @(posedge clk_i);
    endtask

    task automatic report_test(input int num, input string name, input int err_before);
        $display("Test %0d (%s) finished with %0d errors", num, name, err_cnt - err_before);
    endtask

    // ------------------------------
    // Tests
    // ------------------------------
    task automatic check_clear_and_zero_loads();
        int err_before;
        int low_cycles;
        err_before = err_cnt;
        low_cycles = 0;
        do begin
            @(posedge clk_i);
            if (!req_ready_o) begin
                low_cycles++;
            end
        end while (!req_ready_o && low_cycles < 4 * ROWS);
        check_value("ready low cycles after reset", 64'(low_cycles), 64'(ROWS));
        ready_seen = 1'b1;
        for (int i = 0; i < N_T1; i++) begin
            send(rand_addr(), 5'b00000, {next_rand(), next_rand()});
        end
        drain();
        report_test(1, "clear then zero loads", err_before);
    endtask

    task automatic check_amo_or();
        int err_before;
        err_before = err_cnt;
        for (int l = 0; l < REQ_WORDS; l++) begin
            amo_addr[l]    = rand_addr();
            amo_addr[l][3] = l[0];
        end
        // Second pass sees a nonzero old word
        for (int p = 0; p < 2; p++) begin
            for (int l = 0; l < REQ_WORDS; l++) begin
                send(amo_addr[l], 5'b01010, {next_rand(), next_rand()});
                send(amo_addr[l], 5'b00000, 64'h0);
            end
        end
        drain();
        report_test(2, "atomic OR on both lanes", err_before);
    endtask

    task automatic check_lane_and_alias();
        int                err_before;
        logic [ADDR_W-1:0] base;
        logic [ADDR_W-1:0] alias_bits;
        logic [31:0]       r;
        err_before = err_cnt;
        for (int i = 0; i < 2; i++) begin
            base       = rand_addr();
            base[3]    = 1'b0;
            r          = next_rand();
            alias_bits = {r[29:0], 10'b0} | 40'h400;  // Some bit above the row always flips
            send(base, 5'b01010, {next_rand(), next_rand()});
            send(base | 40'h8, 5'b00000, 64'h0);      // Other lane untouched
            send(base ^ alias_bits, 5'b00000, 64'h0);
            send((base | 40'h8) ^ alias_bits, 5'b01010, {next_rand(), next_rand()});
        end
        drain();
        report_test(3, "lane isolation and aliasing", err_before);
    endtask

    task automatic check_other_commands();
        int          err_before;
        logic [4:0]  cmd;
        logic [4:0]  fixed [4];
        logic [31:0] r;
        err_before = err_cnt;
        fixed[0] = 5'b00001;
        fixed[1] = 5'b01011;
        fixed[2] = 5'b11010;
        fixed[3] = 5'b00010;
        for (int i = 0; i < N_T4 / 2; i++) begin
            r = next_rand();
            if (i < 4) begin
                cmd = fixed[i];
            end else begin
                cmd = (r[4:0] == 5'b01010) ? 5'b01011 : r[4:0];
            end
            send(amo_addr[i % REQ_WORDS], cmd, {next_rand(), next_rand()});
            send(amo_addr[i % REQ_WORDS], 5'b00000, 64'h0);
        end
        drain();
        report_test(4, "other commands act as loads", err_before);
    endtask

    task automatic check_random_stream();
        int                err_before;
        logic [31:0]       r;
        logic [4:0]        cmd;
        logic [ADDR_W-1:0] addr;
        time               prev_t;
        err_before = err_cnt;
        prev_t     = 0;
        for (int i = 0; i < N_T5; i++) begin
            r    = next_rand();
            cmd  = r[0] ? 5'b01010 : r[5:1];
            addr = rand_addr();
            if (r[6]) begin
                addr[9:4] = {4'b0, r[8:7]};  // Crowd a few rows for back-to-back hits
            end
            send(addr, cmd, {next_rand(), next_rand()});
            if (i > 0) begin
                check_value("acceptance spacing", 64'(acc_q[$] - prev_t), 64'(CLK_PERIOD));
            end
            prev_t = acc_q[$];
        end
        drain();
        report_test(5, "random back-to-back stream", err_before);
    endtask

    // ------------------------------
    // Response checker
    // ------------------------------
    initial begin
        logic [WORD_W-1:0] exp_data;
        time               acc_t;
        forever begin
            @(posedge clk_i);
            if (ready_seen && !req_ready_o) begin
                $display("Request ready dropped after the clear at time %0t", $time);
                err_cnt++;
            end
            if (rsp_valid_o) begin
                if (exp_q.size() == 0) begin
                    $display("Response at time %0t with no request outstanding", $time);
                    err_cnt++;
                end else begin
                    exp_data = exp_q.pop_front();
                    acc_t    = acc_q.pop_front();
                    check_value("response data", rsp_data_o, exp_data);
                    check_value("response latency", 64'($time - acc_t), 64'(3 * CLK_PERIOD));
                end
            end
        end
    end

    initial begin
        #(WATCHDOG_TIME);
        $display("Watchdog expired before all tests finished");
        $display("Result: FAILED");
        $finish;
    end

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin
        rng_state   = SEED;
        pass_cnt    = 0;
        err_cnt     = 0;
        ready_seen  = 1'b0;
        rst_n_i     = 1'b0;
        req_valid_i = 1'b0;
        req_i       = '0;
        for (int row = 0; row < ROWS; row++) begin
            for (int w = 0; w < REQ_WORDS; w++) begin
                model[row][w] = '0;  // Store is cleared after reset
            end
        end
        repeat (RST_CYCLES) @(posedge clk_i);
        rst_n_i <= 1'b1;

        check_clear_and_zero_loads();
        check_amo_or();
        check_lane_and_alias();
        check_other_commands();
        check_random_stream();

        $display("Checks passed: %0d, errors: %0d", pass_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: ptw_dmem_bridge.f
mem_cfg_pkg.sv
ptw_mem_pkg.sv
ptw_req_decode.sv
line_store_execute.sv
word_result.sv
ptw_dmem_bridge.sv
tb_ptw_dmem_bridge.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the PTW memory bridge testbench with Verilator

set -u

cd "$(dirname "$0")" || exit 1

TOP=tb_ptw_dmem_bridge
FILE_LIST=ptw_dmem_bridge.f
BUILD_DIR=obj_dir
LOG=sim.log

# Compile
verilator --binary --timing \
    --top-module "$TOP" \
    --Mdir "$BUILD_DIR" \
    -o "$TOP" \
    -f "$FILE_LIST"
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

# Run
"./$BUILD_DIR/$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

# Verdict from the log
if grep -q "Result: FAILED" "$LOG"; then
    echo "Testbench reported failure, see $LOG"
    exit 1
fi

echo "Simulation finished without reported failure"
exit 0
